// ==== hdl/fg_pkg.sv ====
/* shared frame layout and sizing for the SPI function generator
   every SPI frame is 56 bits: opcode, 16-bit address, 32-bit data, MSB first */
package fg_pkg;

	// ----------------------------------------------------------------------
	// sizing
	// ----------------------------------------------------------------------

	// SCK rising edges in one complete frame
	parameter int FRAME_BITS = 56;

	// memory word address width, 1024 words or 4096 bytes
	parameter int WAVE_WORD_BITS_DEFAULT = 10;

	// ce0 registers: start, end, command, scratch
	parameter int REG_COUNT = 4;

	// ----------------------------------------------------------------------
	// frame types
	// ----------------------------------------------------------------------

	// other codes are not written but still return readback
	typedef enum logic [7:0] {
		op_write = 8'h01,
		op_read  = 8'h02
	} spi_opcode_t;

	// field order matches the order on the wire
	typedef struct packed {
		spi_opcode_t opcode;
		logic [15:0] address;
		logic [31:0] data;
	} spi_txn_t;

endpackage

// ==== hdl/spi_frame_receiver.sv ====
`timescale 1ns/10ps
/* SPI mode 0 peripheral, sck/mosi/ssel oversampled by word_clock through 2-flop synchronizers.
   each sck half period must last at least 4 word_clock cycles for the readback to arrive in time.
   write frames of the wrong length, or ending while a handshake is open, are dropped */
module spi_frame_receiver (
	input  logic             word_clock,
	input  logic             reset3_word_clock,
	input  logic             sck,
	input  logic             mosi,
	input  logic             ssel,
	output logic             miso,
	output logic             wr_req,
	input  logic             wr_ack,
	output fg_pkg::spi_txn_t wr_txn,
	output logic [15:0]      rd_addr,
	input  logic [31:0]      rd_data
);
	import fg_pkg::*;

	localparam int cnt_bits = $clog2(FRAME_BITS + 1);
	localparam logic [cnt_bits-1:0] frame_count = cnt_bits'(FRAME_BITS);
	// opcode plus address
	localparam logic [cnt_bits-1:0] header_count = cnt_bits'(FRAME_BITS - 32);

	typedef enum logic [1:0] {
		st_idle,
		st_req,
		st_wait_ack_low
	} hs_state_t;

	// [0] meta, [1] synchronized, [2] previous for edge detect
	logic [2:0] sck_pipe;
	logic [2:0] ssel_pipe;
	logic [1:0] mosi_pipe;
	logic sck_rise;
	logic sck_fall;
	logic ssel_low;
	logic ssel_rise;
	logic [cnt_bits-1:0] bit_count;
	logic [FRAME_BITS-1:0] frame_shift;
	logic [31:0] shift_out;
	logic frame_done;
	hs_state_t state;

	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			sck_pipe <= 3'b000;
			ssel_pipe <= 3'b111;
			mosi_pipe <= 2'b00;
		end else begin
			sck_pipe <= {sck_pipe[1:0], sck};
			ssel_pipe <= {ssel_pipe[1:0], ssel};
			mosi_pipe <= {mosi_pipe[0], mosi};
		end
	end

	assign sck_rise = sck_pipe[1] & ~sck_pipe[2];
	assign sck_fall = ~sck_pipe[1] & sck_pipe[2];
	assign ssel_low = ~ssel_pipe[1];
	assign ssel_rise = ssel_pipe[1] & ~ssel_pipe[2];

	// ----------------------------------------------------------------------
	// bit counter, address capture and readback shifter
	// ----------------------------------------------------------------------
	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			bit_count <= '0;
			rd_addr <= '0;
			shift_out <= '0;
		end else if (!ssel_low) begin
			bit_count <= '0;
		end else begin
			if (sck_rise) begin
				// saturate so overlong frames never alias to a full one
				if (bit_count != '1) begin
					bit_count <= bit_count + 1'b1;
				end
				// 24th edge, the last address bit is on mosi now
				if (bit_count == header_count - 1'b1) begin
					rd_addr <= {frame_shift[14:0], mosi_pipe[1]};
				end
			end
			if (sck_fall) begin
				if (bit_count == header_count) begin
					shift_out <= rd_data;
				end else if (bit_count > header_count) begin
					shift_out <= {shift_out[30:0], 1'b0};
				end
			end
		end
	end

	always_ff @(posedge word_clock) begin
		if (ssel_low && sck_rise) begin
			frame_shift <= {frame_shift[FRAME_BITS-2:0], mosi_pipe[1]};
		end
	end

	assign miso = shift_out[31];

	// ----------------------------------------------------------------------
	// four-phase write handshake
	// ----------------------------------------------------------------------
	assign frame_done = ssel_rise && (bit_count == frame_count)
		&& (frame_shift[FRAME_BITS-1 -: 8] == op_write);

	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: if (frame_done) state <= st_req;
				st_req: if (wr_ack) state <= st_wait_ack_low;
				st_wait_ack_low: if (!wr_ack) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	// held while the request is open
	always_ff @(posedge word_clock) begin
		if (state == st_idle && frame_done) begin
			wr_txn <= frame_shift;
		end
	end

	assign wr_req = (state == st_req);

endmodule

// ==== hdl/control_registers.sv ====
`timescale 1ns/10ps
/* ce0 register bank: 0 start byte address, 1 end byte address (exclusive),
   2 command (bit 0 restarts playback), 3 scratch. only the low address bits are decoded */
module control_registers (
	input  logic             word_clock,
	input  logic             reset3_word_clock,
	input  logic             wr_req,
	output logic             wr_ack,
	input  fg_pkg::spi_txn_t wr_txn,
	input  logic [15:0]      rd_addr,
	output logic [31:0]      rd_data,
	output logic [31:0]      start_byte_addr,
	output logic [31:0]      end_byte_addr,
	output logic             restart
);
	import fg_pkg::*;

	localparam int reg_bits = $clog2(REG_COUNT);

	logic [31:0] regs [REG_COUNT];
	logic write_en;
	logic [reg_bits-1:0] wr_index;

	// write lands on the same edge that raises ack
	assign write_en = wr_req && !wr_ack;
	assign wr_index = wr_txn.address[reg_bits-1:0];

	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			wr_ack <= 1'b0;
			restart <= 1'b0;
			rd_data <= '0;
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			wr_ack <= wr_req;
			restart <= write_en && (wr_index == reg_bits'(2)) && wr_txn.data[0];
			if (write_en) begin
				regs[wr_index] <= wr_txn.data;
			end
			rd_data <= regs[rd_addr[reg_bits-1:0]];
		end
	end

	assign start_byte_addr = regs[0];
	assign end_byte_addr = regs[1];

endmodule

// ==== hdl/waveform_memory.sv ====
`timescale 1ns/10ps
/* waveform store, 2**wave_word_bits words of 32 bits, upper host address bits ignored.
   playback reads byte k of a word from bits 31-8k down to 24-8k, so the first SPI byte plays first.
   contents are undefined after power up */
module waveform_memory #(
	parameter int wave_word_bits = 10
) (
	input  logic                      word_clock,
	input  logic                      reset3_word_clock,
	input  logic                      wr_req,
	output logic                      wr_ack,
	input  fg_pkg::spi_txn_t          wr_txn,
	input  logic [15:0]               rd_addr,
	output logic [31:0]               rd_data,
	input  logic [wave_word_bits+1:0] play_byte_addr,
	output logic [7:0]                sample_out
);

	localparam int words = 2 ** wave_word_bits;

	logic [31:0] mem [words];
	logic write_en;
	logic [31:0] play_word;
	logic [1:0] byte_sel;

	assign write_en = wr_req && !wr_ack;

	// ----------------------------------------------------------------------
	// handshake answer
	// ----------------------------------------------------------------------
	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			wr_ack <= 1'b0;
		end else begin
			wr_ack <= wr_req;
		end
	end

	// ----------------------------------------------------------------------
	// storage, host port and playback port
	// ----------------------------------------------------------------------
	always_ff @(posedge word_clock) begin
		if (write_en) begin
			mem[wr_txn.address[wave_word_bits-1:0]] <= wr_txn.data;
		end
		rd_data <= mem[rd_addr[wave_word_bits-1:0]];
	end

	assign play_word = mem[play_byte_addr[wave_word_bits+1:2]];
	assign byte_sel = play_byte_addr[1:0];

	// byte 0 sits in the top lane
	always_ff @(posedge word_clock) begin
		sample_out <= play_word[{~byte_sel, 3'b000} +: 8];
	end

endmodule

// ==== hdl/playback_sequencer.sv ====
`timescale 1ns/10ps
/* cyclic byte address from start to end-1, start and end re-read from the registers at each wrap.
   end <= start holds the address at start with no sync. sync_out lines up with the memory's
   registered sample, so a one-byte loop would raise it every cycle */
module playback_sequencer #(
	parameter int wave_word_bits = 10
) (
	input  logic                      word_clock,
	input  logic                      reset3_word_clock,
	input  logic [31:0]               start_byte_addr,
	input  logic [31:0]               end_byte_addr,
	input  logic                      restart,
	output logic [wave_word_bits+1:0] play_byte_addr,
	output logic                      sync_out
);

	localparam int aw = wave_word_bits + 2;

	// one extra bit so an end at the top of memory still compares
	logic [aw:0] last_q;
	logic run_q;
	logic new_run;
	logic wrap;
	logic sync_raw;

	assign new_run = end_byte_addr > start_byte_addr;
	assign wrap = restart || !run_q || ({1'b0, play_byte_addr} == last_q);

	// ----------------------------------------------------------------------
	// address counter
	// ----------------------------------------------------------------------
	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			play_byte_addr <= '0;
			last_q <= '0;
			run_q <= 1'b0;
			sync_raw <= 1'b0;
		end else if (wrap) begin
			// idle loops here too, re-reading until end > start
			play_byte_addr <= start_byte_addr[aw-1:0];
			last_q <= end_byte_addr[aw:0] - 1'b1;
			run_q <= new_run;
			sync_raw <= new_run;
		end else begin
			play_byte_addr <= play_byte_addr + 1'b1;
			sync_raw <= 1'b0;
		end
	end

	// ----------------------------------------------------------------------
	// sync marker, one cycle behind for the memory read register
	// ----------------------------------------------------------------------
	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			sync_out <= 1'b0;
		end else begin
			sync_out <= sync_raw;
		end
	end

endmodule

// ==== hdl/function_generator_top.sv ====
`timescale 1ns/10ps
/* SPI function generator core, single word_clock domain, reset supplied from outside.
   ce0 reaches the control registers, ce1 the waveform memory; only one select may be low */
module function_generator_top #(
	parameter int wave_word_bits = fg_pkg::WAVE_WORD_BITS_DEFAULT
) (
	input  logic       word_clock,
	input  logic       reset3_word_clock,
	input  logic       spi_sck,
	input  logic       spi_mosi,
	input  logic       spi_ce0,
	input  logic       spi_ce1,
	output logic       spi_miso,
	output logic [7:0] sample_out,
	output logic       sync_out
);
	import fg_pkg::*;

	logic miso_ce0;
	logic miso_ce1;
	logic wr_req_ce0;
	logic wr_ack_ce0;
	spi_txn_t wr_txn_ce0;
	logic [15:0] rd_addr_ce0;
	logic [31:0] rd_data_ce0;
	logic wr_req_ce1;
	logic wr_ack_ce1;
	spi_txn_t wr_txn_ce1;
	logic [15:0] rd_addr_ce1;
	logic [31:0] rd_data_ce1;
	logic [31:0] start_byte_addr;
	logic [31:0] end_byte_addr;
	logic restart;
	logic [wave_word_bits+1:0] play_byte_addr;

	// ----------------------------------------------------------------------
	// SPI side, shared sck and mosi
	// ----------------------------------------------------------------------
	spi_frame_receiver rx_ce0 (
		.word_clock, .reset3_word_clock, .sck(spi_sck), .mosi(spi_mosi), .ssel(spi_ce0),
		.miso(miso_ce0), .wr_req(wr_req_ce0), .wr_ack(wr_ack_ce0), .wr_txn(wr_txn_ce0),
		.rd_addr(rd_addr_ce0), .rd_data(rd_data_ce0));

	spi_frame_receiver rx_ce1 (
		.word_clock, .reset3_word_clock, .sck(spi_sck), .mosi(spi_mosi), .ssel(spi_ce1),
		.miso(miso_ce1), .wr_req(wr_req_ce1), .wr_ack(wr_ack_ce1), .wr_txn(wr_txn_ce1),
		.rd_addr(rd_addr_ce1), .rd_data(rd_data_ce1));

	// whichever select is low owns miso
	always_comb begin
		if (!spi_ce0) begin
			spi_miso = miso_ce0;
		end else if (!spi_ce1) begin
			spi_miso = miso_ce1;
		end else begin
			spi_miso = 1'b0;
		end
	end

	// ----------------------------------------------------------------------
	// registers, memory and playback
	// ----------------------------------------------------------------------
	control_registers regs (
		.word_clock, .reset3_word_clock, .wr_req(wr_req_ce0), .wr_ack(wr_ack_ce0),
		.wr_txn(wr_txn_ce0), .rd_addr(rd_addr_ce0), .rd_data(rd_data_ce0),
		.start_byte_addr, .end_byte_addr, .restart);

	waveform_memory #(.wave_word_bits(wave_word_bits)) wave_mem (
		.word_clock, .reset3_word_clock, .wr_req(wr_req_ce1), .wr_ack(wr_ack_ce1),
		.wr_txn(wr_txn_ce1), .rd_addr(rd_addr_ce1), .rd_data(rd_data_ce1),
		.play_byte_addr, .sample_out);

	playback_sequencer #(.wave_word_bits(wave_word_bits)) seq (
		.word_clock, .reset3_word_clock, .start_byte_addr, .end_byte_addr, .restart,
		.play_byte_addr, .sync_out);

endmodule

// ==== tb/fg_checker.sv ====
`timescale 1ns/10ps
/* protocol checks bound into the SPI receivers and the playback sequencer.
   signals a target does not have are tied off in its bind */
module fg_checker (
	input logic        word_clock,
	input logic        reset3_word_clock,
	input logic        wr_req,
	input logic        wr_ack,
	input logic [55:0] wr_txn,
	input logic        sync_out
);

	// ----------------------------------------------------------------------
	// four-phase write handshake
	// ----------------------------------------------------------------------
	ack_after_req: assert property (@(posedge word_clock) disable iff (reset3_word_clock)
		$rose(wr_ack) |-> $past(wr_req))
		else $error("wr_ack rose without wr_req");

	// payload frozen while the request is open
	txn_stable: assert property (@(posedge word_clock) disable iff (reset3_word_clock)
		wr_req && $past(wr_req) |-> $stable(wr_txn))
		else $error("wr_txn changed while wr_req was high");

	req_held: assert property (@(posedge word_clock) disable iff (reset3_word_clock)
		wr_req && !wr_ack |=> wr_req)
		else $error("wr_req dropped before wr_ack");

	// one pulse per loop start
	sync_single: assert property (@(posedge word_clock) disable iff (reset3_word_clock)
		sync_out |=> !sync_out)
		else $error("sync_out high on two cycles running");

endmodule

bind spi_frame_receiver fg_checker handshake_check (
	.word_clock, .reset3_word_clock, .wr_req, .wr_ack, .wr_txn, .sync_out(1'b0));

bind playback_sequencer fg_checker sync_check (
	.word_clock, .reset3_word_clock, .wr_req(1'b0), .wr_ack(1'b0), .wr_txn(56'd0),
	.sync_out);

// ==== tb/function_generator_tb.sv ====
`timescale 1ns/10ps
/* testbench for function_generator_top, SPI host at 4 word_clocks per sck half period.
   stimulus from a 32-bit Galois LFSR, checked against a register and byte model */
module function_generator_tb;
	import fg_pkg::*;

	localparam int mem_words = 2 ** WAVE_WORD_BITS_DEFAULT;
	// 8 word_clocks per bit plus the trailing and idle gaps
	localparam int frame_cycles = 8 * FRAME_BITS + 8;
	localparam int frame_total = 68;
	localparam int sync_limit = 64;
	localparam int restart_window = 8;
	localparam int watchdog_cycles = 2 * (frame_total * frame_cycles + 8 * sync_limit);

	logic word_clock;
	logic reset3_word_clock;
	logic spi_sck;
	logic spi_mosi;
	logic spi_ce0;
	logic spi_ce1;
	logic spi_miso;
	logic [7:0] sample_out;
	logic sync_out;

	logic [31:0] lfsr;
	logic [31:0] model_regs [REG_COUNT];
	logic [7:0] model_mem [4 * mem_words];
	bit word_valid [mem_words];

	function_generator_top uut (.*);

	initial word_clock = 1'b0;
	always #5 word_clock = ~word_clock;

	// right-shift Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] random_bits(input int width);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < width; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
		end
		return value;
	endfunction

	task automatic step_clocks(input int n);
		repeat (n) @(posedge word_clock);
		#1;
	endtask

	task automatic stop_run();
		$display("sim failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic fail_value(input string name, input logic [31:0] expected,
			input logic [31:0] got);
		$display("Error %s expected %h got %h", name, expected, got);
		stop_run();
	endtask

	task automatic fail_text(input string what);
		$display("%s", what);
		stop_run();
	endtask

	// ----------------------------------------------------------------------
	// SPI host in mode 0 sampling miso on rising sck
	// ----------------------------------------------------------------------
	task automatic spi_frame(input bit mem_sel, input spi_txn_t txn, output logic [31:0] readback);
		logic [FRAME_BITS-1:0] bits;
		bits = txn;
		readback = '0;
		if (mem_sel) begin
			spi_ce1 = 1'b0;
		end else begin
			spi_ce0 = 1'b0;
		end
		for (int i = FRAME_BITS - 1; i >= 0; i--) begin
			spi_mosi = bits[i];
			step_clocks(4);
			spi_sck = 1'b1;
			if (i < 32) begin
				readback = {readback[30:0], spi_miso};
			end
			step_clocks(4);
			spi_sck = 1'b0;
		end
		step_clocks(4);
		spi_ce0 = 1'b1;
		spi_ce1 = 1'b1;
		step_clocks(4);
	endtask

	// frame plus readback check against the model
	task automatic transfer(input bit mem_sel, input logic [7:0] opcode,
			input logic [15:0] address, input logic [31:0] data);
		spi_txn_t txn;
		logic [31:0] expected;
		logic [31:0] got;
		bit known;
		int word_index;
		word_index = int'(address) % mem_words;
		if (mem_sel) begin
			expected = {model_mem[4*word_index], model_mem[4*word_index+1],
				model_mem[4*word_index+2], model_mem[4*word_index+3]};
			known = word_valid[word_index];
		end else begin
			expected = model_regs[address[1:0]];
			known = 1'b1;
		end
		txn.opcode = spi_opcode_t'(opcode);
		txn.address = address;
		txn.data = data;
		spi_frame(mem_sel, txn, got);
		if (known) begin
			assert (got === expected) else fail_value("spi_miso", expected, got);
		end
		// only op_write updates the model
		if (opcode == op_write) begin
			if (mem_sel) begin
				for (int k = 0; k < 4; k++) begin
					model_mem[4*word_index + k] = data[31-8*k -: 8];
				end
				word_valid[word_index] = 1'b1;
			end else begin
				model_regs[address[1:0]] = data;
			end
		end
	endtask

	// waits for sync_out, then follows start..stop-1 for the given periods
	task automatic check_playback(input int start, input int stop, input int periods,
			input int wait_limit);
		int waited;
		int len;
		int n;
		logic [7:0] expected;
		waited = 0;
		len = stop - start;
		while (sync_out !== 1'b1) begin
			assert (waited < wait_limit)
				else fail_text("sync_out did not appear within the expected window");
			step_clocks(1);
			waited++;
		end
		n = 0;
		while (n < periods * len) begin
			// a later sync inside the window is the restart taking effect
			if (sync_out === 1'b1 && waited < wait_limit) begin
				n = 0;
			end
			expected = model_mem[start + n % len];
			assert (sample_out === expected)
				else fail_value("sample_out", 32'(expected), 32'(sample_out));
			assert (sync_out === (n % len == 0))
				else fail_value("sync_out", 32'(n % len == 0), 32'(sync_out));
			step_clocks(1);
			waited++;
			n++;
		end
	endtask

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------
	initial begin
		logic [15:0] mem_addrs [8];
		logic [7:0] opcode;
		int base;
		int start;
		int stop;
		lfsr = 32'hac0e;
		reset3_word_clock = 1'b1;
		spi_sck = 1'b0;
		spi_mosi = 1'b0;
		spi_ce0 = 1'b1;
		spi_ce1 = 1'b1;
		for (int r = 0; r < REG_COUNT; r++) begin
			model_regs[r] = '0;
		end
		repeat (8) begin
			step_clocks(1);
			assert (sync_out === 1'b0) else fail_value("sync_out", 32'h0, 32'(sync_out));
		end
		reset3_word_clock = 1'b0;
		repeat (4) begin
			step_clocks(1);
			assert (sync_out === 1'b0) else fail_value("sync_out", 32'h0, 32'(sync_out));
		end
		// start and end read back as zero after reset
		transfer(1'b0, op_read, 16'd0, random_bits(32));
		transfer(1'b0, op_read, 16'd1, random_bits(32));

		for (int r = 0; r < REG_COUNT; r++) begin
			transfer(1'b0, op_write, 16'(r), random_bits(32));
		end
		for (int r = 0; r < REG_COUNT; r++) begin
			transfer(1'b0, op_read, 16'(r), random_bits(32));
		end

		// full 16-bit addresses wrap onto the low word bits
		for (int n = 0; n < 8; n++) begin
			mem_addrs[n] = 16'(random_bits(16));
			transfer(1'b1, op_write, mem_addrs[n], random_bits(32));
		end
		for (int n = 0; n < 8; n++) begin
			transfer(1'b1, op_read, mem_addrs[n], random_bits(32));
		end

		// loop of 1 to 8 words inside a written region of 16
		base = int'(random_bits(6)) * 16;
		for (int w = 0; w < 16; w++) begin
			transfer(1'b1, op_write, 16'(base + w), random_bits(32));
		end
		start = 4 * (base + int'(random_bits(3)));
		stop = start + 4 * (1 + int'(random_bits(3)));
		transfer(1'b0, op_write, 16'd0, 32'(start));
		transfer(1'b0, op_write, 16'd1, 32'(stop));
		transfer(1'b0, op_write, 16'd2, 32'h1);
		check_playback(start, stop, 3, sync_limit);

		// restart in the middle of a running loop
		transfer(1'b0, op_write, 16'd2, random_bits(32) | 32'h1);
		check_playback(start, stop, 2, restart_window);

		opcode = 8'(random_bits(8));
		while (opcode == op_write || opcode == op_read) begin
			opcode = 8'(random_bits(8));
		end
		transfer(1'b0, opcode, 16'(random_bits(2)), random_bits(32));
		transfer(1'b1, opcode, 16'(base + int'(random_bits(4))), random_bits(32));
		for (int r = 0; r < REG_COUNT; r++) begin
			transfer(1'b0, op_read, 16'(r), random_bits(32));
		end
		for (int w = 0; w < 16; w++) begin
			transfer(1'b1, op_read, 16'(base + w), random_bits(32));
		end

		$display("sim passed");
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge word_clock);
		fail_text("watchdog expired before the tests finished");
	end

endmodule

// ==== compile.f ====
hdl/fg_pkg.sv
hdl/spi_frame_receiver.sv
hdl/control_registers.sv
hdl/waveform_memory.sv
hdl/playback_sequencer.sv
hdl/function_generator_top.sv
tb/fg_checker.sv
tb/function_generator_tb.sv

// ==== Makefile ====
# Verilator build and run of the SPI function generator testbench
TOP = function_generator_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  make test   build with Verilator, run the testbench, log to sim.log"
	@echo "  make clean  remove obj_dir and sim.log"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then \
		echo "test FAILED"; \
		exit 1; \
	fi
	@echo "test PASSED"

clean:
	rm -rf obj_dir sim.log
